//--- hdl/usiRam_macros.svh
`ifndef USIRAM_MACROS_SVH
`define USIRAM_MACROS_SVH

// Bus and RAM widths
`define USIRAM_BUS_W     32
`define USIRAM_DQ_W      16
`define USIRAM_ADRS_W    32
`define USIRAM_DEPTH     16
`define USIRAM_IDX_W     4
`define USIRAM_BURST_LEN 8

// Block select, bits 23..16 of the bus address
`define USIRAM_BLOCK_ID  8'h06

// Register offsets, low byte of the offset field
`define USIRAM_OFS_WD    8'h00
`define USIRAM_OFS_ADRS  8'h04
`define USIRAM_OFS_EN    8'h08
`define USIRAM_OFS_BURST 8'h0C
`define USIRAM_OFS_STAT  8'h40
`define USIRAM_OFS_RD    8'h44
`define USIRAM_OFS_RDVD  8'h48

`endif

//--- hdl/usiRamPkg.sv
`include "usiRam_macros.svh"

package usiRamPkg;

	// Bus side word
	typedef logic [`USIRAM_BUS_W-1:0]  usiWord_t;

	// RAM data and addressing
	typedef logic [`USIRAM_DQ_W-1:0]   ramData_t;
	typedef logic [`USIRAM_ADRS_W-1:0] ramAdrs_t;
	typedef logic [`USIRAM_IDX_W-1:0]  ramIndex_t;

	// Access engine FSM
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		WRITE = 2'd1,
		BURST = 2'd2
	} engineState_t;

endpackage

//--- hdl/ramCsr.sv
`timescale 1ns/1ps
`include "usiRam_macros.svh"

module ramCsr #(
	parameter logic [7:0] pAdrsMap = `USIRAM_BLOCK_ID
)(
	input  logic                 iSCLK,
	input  logic                 iSRST,
	// Bus master side
	input  usiRamPkg::usiWord_t  iSUsiAdrs,
	input  usiRamPkg::usiWord_t  iSUsiWd,
	output usiRamPkg::usiWord_t  oSUsiRd,
	// Control toward the access engine
	output usiRamPkg::ramData_t  ramWd,
	output usiRamPkg::ramAdrs_t  ramAdrs,
	output logic                 ramEn,
	output logic                 ramBurstRun,
	// Status from the access engine
	input  logic                 ramFull,
	input  logic                 ramEmp,
	input  usiRamPkg::ramData_t  ramRd,
	input  logic                 ramRdVd,
	input  logic                 ramBurstStop
);

	logic                blockHit;
	logic                weWd;
	logic                weAdrs;
	logic                weEn;
	logic                weBurst;
	logic                weRdVd;
	logic                statFull;
	logic                statEmp;
	logic                statRdVd;
	usiRamPkg::ramData_t statRd;

	//--------------------------------------------------
	// Write strobe decode
	//--------------------------------------------------
	// Bit 30 marks a write, bits 23..16 pick the block
	assign blockHit = iSUsiAdrs[30] && (iSUsiAdrs[23:16] == pAdrsMap);

	assign weWd    = blockHit && (iSUsiAdrs[15:0] == {8'h00, `USIRAM_OFS_WD});
	assign weAdrs  = blockHit && (iSUsiAdrs[15:0] == {8'h00, `USIRAM_OFS_ADRS});
	assign weEn    = blockHit && (iSUsiAdrs[15:0] == {8'h00, `USIRAM_OFS_EN});
	assign weBurst = blockHit && (iSUsiAdrs[15:0] == {8'h00, `USIRAM_OFS_BURST});
	assign weRdVd  = blockHit && (iSUsiAdrs[15:0] == {8'h00, `USIRAM_OFS_RDVD});

	//--------------------------------------------------
	// Control registers
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			ramWd       <= '0;
			ramAdrs     <= '0;
			ramEn       <= 1'b0;
			ramBurstRun <= 1'b0;
		end
		else
		begin
			if (weWd)
			begin
				ramWd <= iSUsiWd[`USIRAM_DQ_W-1:0];
			end
			if (weAdrs)
			begin
				ramAdrs <= iSUsiWd;
			end
			if (weEn)
			begin
				ramEn <= iSUsiWd[0];
			end
			// Engine stop wins over a bus write
			if (ramBurstStop)
			begin
				ramBurstRun <= 1'b0;
			end
			else if (weBurst)
			begin
				ramBurstRun <= iSUsiWd[0];
			end
		end
	end

	// Status capture, one cycle behind the engine
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			statFull <= 1'b0;
			statEmp  <= 1'b0;
			statRdVd <= 1'b0;
		end
		else
		begin
			statFull <= ramFull;
			statEmp  <= ramEmp;
			// Sticky, a fresh pulse beats the clear
			if (ramRdVd)
			begin
				statRdVd <= 1'b1;
			end
			else if (weRdVd)
			begin
				statRdVd <= 1'b0;
			end
		end
	end

	always_ff @(posedge iSCLK)
	begin
		statRd <= ramRd;
	end

	//--------------------------------------------------
	// Read multiplexer
	//--------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		case (iSUsiAdrs[7:0])
			`USIRAM_OFS_WD:    oSUsiRd <= usiRamPkg::usiWord_t'(ramWd);
			`USIRAM_OFS_ADRS:  oSUsiRd <= ramAdrs;
			`USIRAM_OFS_EN:    oSUsiRd <= usiRamPkg::usiWord_t'(ramEn);
			`USIRAM_OFS_BURST: oSUsiRd <= usiRamPkg::usiWord_t'(ramBurstRun);
			// Full in bit 0, empty in bit 4
			`USIRAM_OFS_STAT:  oSUsiRd <= usiRamPkg::usiWord_t'({statEmp, 3'b000, statFull});
			`USIRAM_OFS_RD:    oSUsiRd <= usiRamPkg::usiWord_t'(statRd);
			`USIRAM_OFS_RDVD:  oSUsiRd <= usiRamPkg::usiWord_t'(statRdVd);
			default:           oSUsiRd <= iSUsiWd;
		endcase
	end

	// Engine may only end a burst that this block started
	assert property (@(posedge iSCLK) disable iff (iSRST)
		ramBurstStop |-> ramBurstRun)
		else $error("ramBurstStop while ramBurstRun is low");

endmodule

//--- hdl/ramAccessEngine.sv
`timescale 1ns/1ps
`include "usiRam_macros.svh"

module ramAccessEngine (
	input  logic                 iSCLK,
	input  logic                 iSRST,
	// Control from the register block
	input  usiRamPkg::ramData_t  ramWd,
	input  usiRamPkg::ramAdrs_t  ramAdrs,
	input  logic                 ramEn,
	input  logic                 ramBurstRun,
	// Status to the register block
	output logic                 ramFull,
	output logic                 ramEmp,
	output usiRamPkg::ramData_t  ramRd,
	output logic                 ramRdVd,
	output logic                 ramBurstStop,
	// RAM array ports
	output logic                 wrEn,
	output usiRamPkg::ramIndex_t wrIdx,
	output usiRamPkg::ramData_t  wrData,
	output logic                 rdEn,
	output usiRamPkg::ramIndex_t rdIdx,
	input  usiRamPkg::ramData_t  rdData
);

	usiRamPkg::engineState_t state;
	usiRamPkg::engineState_t stateNext;
	usiRamPkg::ramIndex_t    burstCnt;
	logic                    ramEnPrev;
	logic                    enRise;
	logic                    wrPend;
	logic                    wrReq;
	logic                    burstReq;
	logic                    burstLast;
	logic [`USIRAM_DEPTH-1:0] validMap;

	//--------------------------------------------------
	// Request detection
	//--------------------------------------------------
	assign enRise = ramEn & ~ramEnPrev;
	assign wrReq  = enRise | wrPend;
	// A stop in flight means ramBurstRun drops on the next edge
	assign burstReq  = ramBurstRun & ~ramBurstStop;
	assign burstLast = (burstCnt == usiRamPkg::ramIndex_t'(`USIRAM_BURST_LEN - 1));

	always_comb
	begin
		stateNext = state;
		case (state)
			usiRamPkg::IDLE:
			begin
				if (wrReq)
				begin
					stateNext = usiRamPkg::WRITE;
				end
				else if (burstReq)
				begin
					stateNext = usiRamPkg::BURST;
				end
			end
			usiRamPkg::WRITE: stateNext = usiRamPkg::IDLE;
			usiRamPkg::BURST:
			begin
				if (burstLast)
				begin
					stateNext = usiRamPkg::IDLE;
				end
			end
			default: stateNext = usiRamPkg::IDLE;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state        <= usiRamPkg::IDLE;
			burstCnt     <= '0;
			ramEnPrev    <= 1'b0;
			wrPend       <= 1'b0;
			ramRdVd      <= 1'b0;
			ramBurstStop <= 1'b0;
		end
		else
		begin
			state     <= stateNext;
			ramEnPrev <= ramEn;
			// Edge seen outside IDLE is held until the engine is free
			wrPend    <= (state != usiRamPkg::IDLE) & wrReq;
			burstCnt  <= rdEn ? burstCnt + 1'b1 : '0;
			// Read data comes back one stage behind the issue
			ramRdVd      <= rdEn;
			ramBurstStop <= rdEn & burstLast;
		end
	end

	//--------------------------------------------------
	// Array access and valid map
	//--------------------------------------------------
	assign wrEn   = (state == usiRamPkg::WRITE);
	assign wrIdx  = ramAdrs[`USIRAM_IDX_W-1:0];
	assign wrData = ramWd;
	assign rdEn   = (state == usiRamPkg::BURST);
	// Index wraps modulo depth
	assign rdIdx  = ramAdrs[`USIRAM_IDX_W-1:0] + burstCnt;
	assign ramRd  = rdData;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			validMap <= '0;
		end
		else if (wrEn)
		begin
			validMap[wrIdx] <= 1'b1;
		end
		else if (rdEn)
		begin
			validMap[rdIdx] <= 1'b0;
		end
	end

	assign ramFull = &validMap;
	assign ramEmp  = ~|validMap;

	// Reads only while the register block holds the burst running
	assert property (@(posedge iSCLK) disable iff (iSRST)
		rdEn |-> ramBurstRun)
		else $error("rdEn outside a running burst");

	// Stop marks the last returned word
	assert property (@(posedge iSCLK) disable iff (iSRST)
		ramBurstStop |-> ramRdVd ##1 !ramRdVd)
		else $error("ramBurstStop without the last ramRdVd");

endmodule

//--- hdl/ramArray.sv
`timescale 1ns/1ps
`include "usiRam_macros.svh"

module ramArray (
	input  logic                 iSCLK,
	// Write port
	input  logic                 wrEn,
	input  usiRamPkg::ramIndex_t wrIdx,
	input  usiRamPkg::ramData_t  wrData,
	// Read port, data one cycle after rdEn
	input  logic                 rdEn,
	input  usiRamPkg::ramIndex_t rdIdx,
	output usiRamPkg::ramData_t  rdData
);

	usiRamPkg::ramData_t mem [`USIRAM_DEPTH];

	always_ff @(posedge iSCLK)
	begin
		if (wrEn)
		begin
			mem[wrIdx] <= wrData;
		end
	end

	// Output register holds its value between reads
	always_ff @(posedge iSCLK)
	begin
		if (rdEn)
		begin
			rdData <= mem[rdIdx];
		end
	end

endmodule

//--- hdl/usiRamTop.sv
`timescale 1ns/1ps
`include "usiRam_macros.svh"

module usiRamTop (
	input  logic                iSCLK,
	input  logic                iSRST,
	input  usiRamPkg::usiWord_t iSUsiAdrs,
	input  usiRamPkg::usiWord_t iSUsiWd,
	output usiRamPkg::usiWord_t oSUsiRd
);

	// Register block to engine
	usiRamPkg::ramData_t  ramWd;
	usiRamPkg::ramAdrs_t  ramAdrs;
	logic                 ramEn;
	logic                 ramBurstRun;
	// Engine to register block
	logic                 ramFull;
	logic                 ramEmp;
	usiRamPkg::ramData_t  ramRd;
	logic                 ramRdVd;
	logic                 ramBurstStop;
	// Engine to array
	logic                 wrEn;
	usiRamPkg::ramIndex_t wrIdx;
	usiRamPkg::ramData_t  wrData;
	logic                 rdEn;
	usiRamPkg::ramIndex_t rdIdx;
	usiRamPkg::ramData_t  rdData;

	ramCsr #(
		.pAdrsMap (`USIRAM_BLOCK_ID)
	) uRamCsr (
		.iSCLK, .iSRST, .iSUsiAdrs, .iSUsiWd, .oSUsiRd,
		.ramWd, .ramAdrs, .ramEn, .ramBurstRun,
		.ramFull, .ramEmp, .ramRd, .ramRdVd, .ramBurstStop
	);

	ramAccessEngine uRamAccessEngine (
		.iSCLK, .iSRST,
		.ramWd, .ramAdrs, .ramEn, .ramBurstRun,
		.ramFull, .ramEmp, .ramRd, .ramRdVd, .ramBurstStop,
		.wrEn, .wrIdx, .wrData, .rdEn, .rdIdx, .rdData
	);

	ramArray uRamArray (
		.iSCLK,
		.wrEn, .wrIdx, .wrData,
		.rdEn, .rdIdx, .rdData
	);

endmodule

//--- dv/usiRamChecker.sv
`timescale 1ns/1ps

module usiRamChecker (
	input  logic                iSCLK,
	input  logic                iSRST,
	// Expected value, valid with the read address
	input  logic                cmpStrobe,
	input  usiRamPkg::usiWord_t expData,
	// Registered bus read data of the DUT
	input  usiRamPkg::usiWord_t usiRd,
	output int                  errCount,
	output int                  checkCount
);

	logic                cmpPend;
	usiRamPkg::usiWord_t expPend;

	// Read data lands one cycle after the address
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			cmpPend    <= 1'b0;
			expPend    <= '0;
			errCount   <= 0;
			checkCount <= 0;
		end
		else
		begin
			cmpPend <= cmpStrobe;
			expPend <= expData;
			if (cmpPend)
			begin
				checkCount <= checkCount + 1;
				if (usiRd !== expPend)
				begin
					$display("** Error oSUsiRd exp %08h got %08h", expPend, usiRd);
					errCount <= errCount + 1;
				end
			end
		end
	end

endmodule

//--- dv/usiRamTb.sv
`timescale 1ns/1ps
`include "usiRam_macros.svh"

module usiRamTb;

	localparam int numTests = 5;
	localparam int maxPolls = 50;

	logic                     iSCLK;
	logic                     iSRST;
	usiRamPkg::usiWord_t      iSUsiAdrs;
	usiRamPkg::usiWord_t      iSUsiWd;
	usiRamPkg::usiWord_t      oSUsiRd;
	logic                     cmpStrobe;
	usiRamPkg::usiWord_t      expData;
	int                       errCount;
	int                       checkCount;
	int                       failCount;
	int                       testsFailed;
	int                       errMark;
	integer                   seed;
	// Reference model state
	usiRamPkg::ramData_t      mdlWd;
	usiRamPkg::ramAdrs_t      mdlAdrs;
	logic                     mdlEn;
	logic                     mdlRdVd;
	usiRamPkg::ramData_t      mdlRd;
	usiRamPkg::ramData_t      mdlMem [`USIRAM_DEPTH];
	logic [`USIRAM_DEPTH-1:0] mdlValid;

	usiRamTop uut (.iSCLK, .iSRST, .iSUsiAdrs, .iSUsiWd, .oSUsiRd);

	usiRamChecker uChecker (
		.iSCLK, .iSRST, .cmpStrobe, .expData,
		.usiRd (oSUsiRd), .errCount, .checkCount
	);

	initial iSCLK = 1'b0;
	always #2 iSCLK = ~iSCLK;

	//--------------------------------------------------
	// Reference model
	//--------------------------------------------------
	function automatic usiRamPkg::usiWord_t refRead(input logic [7:0] ofs,
		input usiRamPkg::usiWord_t wd);
		usiRamPkg::usiWord_t r;
		case (ofs)
			`USIRAM_OFS_WD:    r = {16'h0000, mdlWd};
			`USIRAM_OFS_ADRS:  r = mdlAdrs;
			`USIRAM_OFS_EN:    r = {31'd0, mdlEn};
			// Every burst is over before the run flag is read
			`USIRAM_OFS_BURST: r = '0;
			`USIRAM_OFS_STAT:  r = {27'd0, ~|mdlValid, 3'b000, &mdlValid};
			`USIRAM_OFS_RD:    r = {16'h0000, mdlRd};
			`USIRAM_OFS_RDVD:  r = {31'd0, mdlRdVd};
			// Unmapped offsets echo the write data
			default:           r = wd;
		endcase
		return r;
	endfunction

	function automatic void modelWrite(input usiRamPkg::usiWord_t adrs,
		input usiRamPkg::usiWord_t wd);
		usiRamPkg::ramIndex_t idx;
		if (adrs[30] && (adrs[23:16] == `USIRAM_BLOCK_ID) && (adrs[15:8] == 8'h00))
		begin
			case (adrs[7:0])
				`USIRAM_OFS_WD:   mdlWd = wd[`USIRAM_DQ_W-1:0];
				`USIRAM_OFS_ADRS: mdlAdrs = wd;
				`USIRAM_OFS_EN:
				begin
					// Only a rising enable stores a word
					if (wd[0] && !mdlEn)
					begin
						idx = mdlAdrs[`USIRAM_IDX_W-1:0];
						mdlMem[idx] = mdlWd;
						mdlValid[idx] = 1'b1;
					end
					mdlEn = wd[0];
				end
				`USIRAM_OFS_BURST:
				begin
					// Whole burst at once, the test waits for its end
					if (wd[0])
					begin
						for (int i = 0; i < `USIRAM_BURST_LEN; i++)
						begin
							idx = mdlAdrs[`USIRAM_IDX_W-1:0] + i[`USIRAM_IDX_W-1:0];
							mdlRd = mdlMem[idx];
							mdlValid[idx] = 1'b0;
						end
						mdlRdVd = 1'b1;
					end
				end
				`USIRAM_OFS_RDVD: mdlRdVd = 1'b0;
				default: ;
			endcase
		end
	endfunction

	//--------------------------------------------------
	// Bus tasks
	//--------------------------------------------------
	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge iSCLK);
			#0.5;
		end
	endtask

	task automatic busCycle(input usiRamPkg::usiWord_t adrs, input usiRamPkg::usiWord_t wd);
		iSUsiAdrs = adrs;
		iSUsiWd   = wd;
		@(posedge iSCLK);
		#0.5;
		iSUsiAdrs = '0;
		iSUsiWd   = '0;
	endtask

	task automatic busWrite(input logic [7:0] block, input logic [7:0] ofs,
		input usiRamPkg::usiWord_t wd);
		usiRamPkg::usiWord_t adrs;
		adrs = {2'b01, 6'd0, block, 8'h00, ofs};
		modelWrite(adrs, wd);
		busCycle(adrs, wd);
	endtask

	task automatic readCheck(input logic [7:0] ofs, input usiRamPkg::usiWord_t wd);
		expData   = refRead(ofs, wd);
		cmpStrobe = 1'b1;
		busCycle({8'h00, `USIRAM_BLOCK_ID, 8'h00, ofs}, wd);
		cmpStrobe = 1'b0;
	endtask

	task automatic singleWrite(input usiRamPkg::ramIndex_t idx,
		input usiRamPkg::ramData_t data, input logic clearEn);
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_ADRS, {28'd0, idx});
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_WD, {16'h0000, data});
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_EN, 32'd1);
		idle(4);
		if (clearEn)
		begin
			busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_EN, 32'd0);
		end
	endtask

	task automatic runBurst(input usiRamPkg::ramIndex_t start);
		int  polls;
		logic done;
		polls = 0;
		done  = 1'b0;
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_ADRS, {28'd0, start});
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_BURST, 32'd1);
		// Run flag drops once the engine reports the last word
		while (!done && (polls < maxPolls))
		begin
			busCycle({8'h00, `USIRAM_BLOCK_ID, 8'h00, `USIRAM_OFS_BURST}, '0);
			done  = (oSUsiRd == '0);
			polls = polls + 1;
		end
		if (!done)
		begin
			$display("Burst from index %0d still running after %0d polls", start, maxPolls);
			failCount = failCount + 1;
		end
		idle(2);
	endtask

	task automatic endTest(input int num, input string name);
		int errs;
		idle(2);
		errs = errCount + failCount - errMark;
		if (errs == 0)
		begin
			$display("Test %0d %s: passed", num, name);
		end
		else
		begin
			$display("Test %0d %s: failed with %0d errors", num, name, errs);
			testsFailed = testsFailed + 1;
		end
		errMark = errCount + failCount;
	endtask

	//--------------------------------------------------
	// Test sequence
	//--------------------------------------------------
	initial
	begin : mainSeq
		usiRamPkg::usiWord_t  rnd;
		usiRamPkg::ramIndex_t start;
		usiRamPkg::ramIndex_t idx;
		seed        = 99207;
		iSRST       = 1'b1;
		iSUsiAdrs   = '0;
		iSUsiWd     = '0;
		cmpStrobe   = 1'b0;
		expData     = '0;
		failCount   = 0;
		testsFailed = 0;
		mdlWd       = '0;
		mdlAdrs     = '0;
		mdlEn       = 1'b0;
		mdlRdVd     = 1'b0;
		mdlRd       = '0;
		mdlValid    = '0;
		for (int i = 0; i < `USIRAM_DEPTH; i++)
		begin
			mdlMem[i] = '0;
		end
		repeat (5) @(posedge iSCLK);
		#0.5;
		iSRST = 1'b0;
		idle(2);
		errMark = errCount;

		readCheck(`USIRAM_OFS_WD, '0);
		readCheck(`USIRAM_OFS_ADRS, '0);
		readCheck(`USIRAM_OFS_EN, '0);
		readCheck(`USIRAM_OFS_BURST, '0);
		readCheck(`USIRAM_OFS_STAT, '0);
		readCheck(`USIRAM_OFS_RDVD, '0);
		endTest(1, "reset values");

		rnd = $random(seed);
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_WD, rnd);
		rnd = $random(seed);
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_ADRS, rnd);
		readCheck(`USIRAM_OFS_WD, '0);
		readCheck(`USIRAM_OFS_ADRS, '0);
		// Writes to a neighbouring block
		rnd = $random(seed);
		busWrite(8'h07, `USIRAM_OFS_WD, rnd);
		busWrite(8'h07, `USIRAM_OFS_ADRS, rnd);
		readCheck(`USIRAM_OFS_WD, '0);
		readCheck(`USIRAM_OFS_ADRS, '0);
		rnd = $random(seed);
		readCheck(8'h20, rnd);
		rnd = $random(seed);
		readCheck(8'hF0, rnd);
		endTest(2, "register access");

		// Last index written is start+7, read back by the burst
		rnd   = $random(seed);
		start = rnd[`USIRAM_IDX_W-1:0];
		for (int k = 0; k < `USIRAM_DEPTH; k++)
		begin
			idx = start + 4'd8 + k[`USIRAM_IDX_W-1:0];
			rnd = $random(seed);
			singleWrite(idx, rnd[`USIRAM_DQ_W-1:0], k != (`USIRAM_DEPTH - 1));
		end
		readCheck(`USIRAM_OFS_STAT, '0);
		readCheck(`USIRAM_OFS_EN, '0);
		// Enable stays high, new data must not land
		rnd = $random(seed);
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_WD, rnd);
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_EN, 32'd1);
		idle(4);
		readCheck(`USIRAM_OFS_WD, '0);
		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_EN, 32'd0);
		endTest(3, "single writes");

		runBurst(start);
		readCheck(`USIRAM_OFS_BURST, '0);
		readCheck(`USIRAM_OFS_RD, '0);
		readCheck(`USIRAM_OFS_RDVD, '0);
		readCheck(`USIRAM_OFS_STAT, '0);
		endTest(4, "first burst");

		busWrite(`USIRAM_BLOCK_ID, `USIRAM_OFS_RDVD, 32'd1);
		readCheck(`USIRAM_OFS_RDVD, '0);
		runBurst(start + 4'd8);
		readCheck(`USIRAM_OFS_STAT, '0);
		readCheck(`USIRAM_OFS_RD, '0);
		readCheck(`USIRAM_OFS_RDVD, '0);
		endTest(5, "second burst");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			numTests, testsFailed, checkCount, errCount + failCount);
		if ((testsFailed == 0) && (errCount == 0) && (failCount == 0))
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Run limit scales with the number of tests
	initial
	begin : watchdog
		#(numTests * 2000);
		$display("Watchdog expired after %0d ns, run stopped", numTests * 2000);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- usiRamSubsys.f
+incdir+hdl
hdl/usiRamPkg.sv
hdl/ramCsr.sv
hdl/ramAccessEngine.sv
hdl/ramArray.sv
hdl/usiRamTop.sv
dv/usiRamChecker.sv
dv/usiRamTb.sv

//--- Makefile
TOP   = usiRamTb
FLIST = usiRamSubsys.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
		echo "Failure reported, see sim.log"; \
		exit 1; \
	fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
